// ==== Makefile ====
# Verilator flow for the peripheral interface adapter.
TOP = cia_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f cia.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cia.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== cia.f ====
+incdir+verilog
verilog/cia_reg_pkg.sv
verilog/cia_timer_pkg.sv
verilog/cia_bus_decode.sv
verilog/cia_io_ports.sv
verilog/cia_timers.sv
verilog/cia_interrupt_ctrl.sv
verilog/cia_top.sv
test/cia_properties.sv
test/cia_tb.sv

// ==== test/cia_properties.sv ====
/*
 * Concurrent assertions on the adapter top-level ports.
 * PC pulse width, IRQ known after reset, output enables cleared by reset.
 */

`timescale 1ns/1ps
`include "cia_cfg.svh"

module cia_properties (
    input logic                     CNT,
    input logic                     RESET_n,
    input logic                     cs,
    input logic [`CIA_ADDR_W-1:0]   addr,
    input logic                     pc_n,
    input logic                     irq_n,
    input cia_reg_pkg::byte_t       pa_oe,
    input cia_reg_pkg::byte_t       pb_oe
);

    int fail_count = 0;

    // A second low cycle needs a fresh port B access.
    pc_single_low: assert property (
        @(posedge CNT) disable iff (!RESET_n)
        !pc_n |=> (pc_n || $past(cs && addr == cia_reg_pkg::REG_PRB))
    ) else begin
        fail_count++;
        $error("pc_n stayed low without a new port B access");
    end

    irq_known: assert property (
        @(posedge CNT) disable iff (!RESET_n)
        !$isunknown(irq_n)
    ) else begin
        fail_count++;
        $error("irq_n is unknown while out of reset");
    end

    // Pins are inputs when reset lets go.
    oe_after_reset: assert property (
        @(posedge CNT)
        $rose(RESET_n) |-> (pa_oe == '0 && pb_oe == '0)
    ) else begin
        fail_count++;
        $error("output enables not cleared by reset");
    end

endmodule

// ==== test/cia_tb.sv ====
/*
 * Testbench for the adapter top level.
 * Clock, reset, bus stimulus, pin model, cycle reference model,
 * output checker and cycle limit.
 */

`timescale 1ns/1ps
`include "cia_cfg.svh"

module cia_tb;

    localparam int RESET_CYCLES = 3;
    // Worst-case lengths of the port, timer A, one-shot, cascade and FLAG tests.
    localparam int TEST_CYCLES  = RESET_CYCLES + 60 + 160 + 60 + 90 + 30;
    localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;

    logic                   CNT;
    logic                   RESET_n;
    logic                   cs;
    logic                   we;
    logic [`CIA_ADDR_W-1:0] addr;
    cia_reg_pkg::byte_t     wdata, rdata;
    cia_reg_pkg::byte_t     pa_in, pa_out, pa_oe, pa_ext;
    cia_reg_pkg::byte_t     pb_in, pb_out, pb_oe, pb_ext;
    logic                   flag_n;
    logic                   pc_n;
    logic                   irq_n;

    // Reference model state.
    cia_reg_pkg::byte_t     m_pra, m_prb, m_ddra, m_ddrb;
    logic [15:0]            m_ta_cnt, m_ta_lat, m_tb_cnt, m_tb_lat;
    logic                   m_ta_run, m_ta_os, m_tb_run, m_tb_os, m_tb_casc;
    logic [4:0]             m_mask, m_flags;
    logic                   m_prb_acc, m_flag_q;

    int                     cycle_count = 0;
    cia_reg_pkg::byte_t     lat_a, lat_b;

    cia_top i_cia_top (
        .CNT(CNT), .RESET_n(RESET_n), .cs(cs), .we(we), .addr(addr),
        .wdata(wdata), .rdata(rdata),
        .pa_in(pa_in), .pa_out(pa_out), .pa_oe(pa_oe),
        .pb_in(pb_in), .pb_out(pb_out), .pb_oe(pb_oe),
        .flag_n(flag_n), .pc_n(pc_n), .irq_n(irq_n)
    );

    bind cia_top cia_properties i_cia_properties (
        .CNT(CNT), .RESET_n(RESET_n), .cs(cs), .addr(addr),
        .pc_n(pc_n), .irq_n(irq_n), .pa_oe(pa_oe), .pb_oe(pb_oe)
    );

    // Driven pins show the port value, the others the outside world.
    assign pa_in = (pa_out & pa_oe) | (pa_ext & ~pa_oe);
    assign pb_in = (pb_out & pb_oe) | (pb_ext & ~pb_oe);

    initial begin
        CNT = 1'b0;
        forever #20 CNT = ~CNT;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            abort_run("A DUT output differed from the reference model.");
        end
    endtask

    function automatic void clear_model();
        m_pra     = '0;
        m_prb     = '0;
        m_ddra    = '0;
        m_ddrb    = '0;
        m_ta_cnt  = '0;
        m_ta_lat  = '0;
        m_tb_cnt  = '0;
        m_tb_lat  = '0;
        m_ta_run  = 1'b0;
        m_ta_os   = 1'b0;
        m_tb_run  = 1'b0;
        m_tb_os   = 1'b0;
        m_tb_casc = 1'b0;
        m_mask    = '0;
        m_flags   = '0;
        m_prb_acc = 1'b0;
        m_flag_q  = 1'b1;
    endfunction

    // Force load first, then a HI write to a stopped timer, then counting.
    function automatic logic [15:0] next_count(input logic [15:0] cnt, input logic [15:0] lat,
            input logic force_ld, input logic hi_ld, input logic step, input logic uf);
        if (force_ld)
            return lat;
        if (hi_ld)
            return {wdata, lat[7:0]};
        if (step)
            return uf ? lat : cnt - 16'h1;
        return cnt;
    endfunction

    // Returns {rdata, irq_n, pc_n} for this cycle, then takes the clock edge.
    function automatic logic [9:0] predict_cycle();
        cia_reg_pkg::byte_t pa_pin, pb_pin, rd;
        logic               ta_uf, tb_step, tb_uf, irq, wr, wr_cra, wr_crb;
        logic [4:0]         src;
        pa_pin  = (m_pra & m_ddra) | (pa_ext & ~m_ddra);
        pb_pin  = (m_prb & m_ddrb) | (pb_ext & ~m_ddrb);
        ta_uf   = m_ta_run && m_ta_cnt == 16'h0;
        tb_step = m_tb_run && (!m_tb_casc || ta_uf);
        tb_uf   = tb_step && m_tb_cnt == 16'h0;
        irq     = |(m_flags & m_mask);
        case (cia_reg_pkg::reg_addr_e'(addr))
            cia_reg_pkg::REG_PRA:   rd = pa_pin;
            cia_reg_pkg::REG_PRB:   rd = pb_pin;
            cia_reg_pkg::REG_DDRA:  rd = m_ddra;
            cia_reg_pkg::REG_DDRB:  rd = m_ddrb;
            cia_reg_pkg::REG_TA_LO: rd = m_ta_cnt[7:0];
            cia_reg_pkg::REG_TA_HI: rd = m_ta_cnt[15:8];
            cia_reg_pkg::REG_TB_LO: rd = m_tb_cnt[7:0];
            cia_reg_pkg::REG_TB_HI: rd = m_tb_cnt[15:8];
            cia_reg_pkg::REG_ICR:   rd = {irq, 2'b00, m_flags};
            cia_reg_pkg::REG_CRA:   rd = {4'h0, m_ta_os, 2'b00, m_ta_run};
            cia_reg_pkg::REG_CRB:   rd = {1'b0, m_tb_casc, 2'b00, m_tb_os, 2'b00, m_tb_run};
            default:                rd = 8'h00;
        endcase
        predict_cycle = {rd, ~irq, ~m_prb_acc};

        wr     = cs && we;
        wr_cra = wr && addr == cia_reg_pkg::REG_CRA;
        wr_crb = wr && addr == cia_reg_pkg::REG_CRB;
        src    = {m_flag_q && !flag_n, 2'b00, tb_uf, ta_uf};
        m_ta_cnt = next_count(m_ta_cnt, m_ta_lat, wr_cra && wdata[4],
                              wr && addr == cia_reg_pkg::REG_TA_HI && !m_ta_run, m_ta_run, ta_uf);
        m_tb_cnt = next_count(m_tb_cnt, m_tb_lat, wr_crb && wdata[4],
                              wr && addr == cia_reg_pkg::REG_TB_HI && !m_tb_run, tb_step, tb_uf);
        if (wr_cra) begin
            m_ta_run = wdata[0];
            m_ta_os  = wdata[3];
        end else if (ta_uf && m_ta_os) begin
            m_ta_run = 1'b0;
        end
        if (wr_crb) begin
            m_tb_run  = wdata[0];
            m_tb_os   = wdata[3];
            m_tb_casc = wdata[6];
        end else if (tb_uf && m_tb_os) begin
            m_tb_run = 1'b0;
        end
        if (wr && addr == cia_reg_pkg::REG_TA_LO)
            m_ta_lat[7:0] = wdata;
        if (wr && addr == cia_reg_pkg::REG_TA_HI)
            m_ta_lat[15:8] = wdata;
        if (wr && addr == cia_reg_pkg::REG_TB_LO)
            m_tb_lat[7:0] = wdata;
        if (wr && addr == cia_reg_pkg::REG_TB_HI)
            m_tb_lat[15:8] = wdata;
        if (wr && addr == cia_reg_pkg::REG_PRA)
            m_pra = wdata;
        if (wr && addr == cia_reg_pkg::REG_PRB)
            m_prb = wdata;
        if (wr && addr == cia_reg_pkg::REG_DDRA)
            m_ddra = wdata;
        if (wr && addr == cia_reg_pkg::REG_DDRB)
            m_ddrb = wdata;
        if (wr && addr == cia_reg_pkg::REG_ICR)
            m_mask = wdata[7] ? (m_mask | wdata[4:0]) : (m_mask & ~wdata[4:0]);
        m_flags   = (cs && !we && addr == cia_reg_pkg::REG_ICR) ? src : (m_flags | src);
        m_prb_acc = cs && addr == cia_reg_pkg::REG_PRB;
        m_flag_q  = flag_n;
    endfunction

    // Outputs still hold their pre-edge values here.
    always @(posedge CNT) begin
        logic [9:0] expected;
        if (!RESET_n) begin
            clear_model();
        end else begin
            check_value("pa_out", pa_out, m_pra);
            check_value("pa_oe", pa_oe, m_ddra);
            check_value("pb_out", pb_out, m_prb);
            check_value("pb_oe", pb_oe, m_ddrb);
            expected = predict_cycle();
            check_value("rdata", rdata, expected[9:2]);
            check_value("irq_n", 8'(irq_n), 8'(expected[1]));
            check_value("pc_n", 8'(pc_n), 8'(expected[0]));
        end
    end

    always @(posedge CNT) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            abort_run("Timeout: the tests did not finish within the cycle limit.");
    end

    always @(i_cia_top.i_cia_properties.fail_count) begin
        if (i_cia_top.i_cia_properties.fail_count != 0)
            abort_run("An assertion on the DUT ports failed.");
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge CNT);
    endtask

    task automatic write_reg(input cia_reg_pkg::reg_addr_e a, input cia_reg_pkg::byte_t d);
        @(negedge CNT);
        cs    = 1'b1;
        we    = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge CNT);
        cs = 1'b0;
        we = 1'b0;
    endtask

    task automatic read_reg(input cia_reg_pkg::reg_addr_e a);
        @(negedge CNT);
        cs   = 1'b1;
        we   = 1'b0;
        addr = a;
        @(negedge CNT);
        cs = 1'b0;
    endtask

    task automatic wait_irq();
        while (irq_n !== 1'b0)
            @(negedge CNT);
    endtask

    initial begin
        RESET_n = 1'b0;
        cs      = 1'b0;
        we      = 1'b0;
        addr    = '0;
        wdata   = '0;
        pa_ext  = '0;
        pb_ext  = '0;
        flag_n  = 1'b1;
        void'($urandom(32'ha97022f0));
        repeat (RESET_CYCLES) @(posedge CNT);
        @(negedge CNT);
        RESET_n = 1'b1;

        // Ports, direction registers and pin readback.
        repeat (4) begin
            pa_ext = 8'($urandom);
            pb_ext = 8'($urandom);
            write_reg(cia_reg_pkg::REG_DDRA, 8'($urandom));
            write_reg(cia_reg_pkg::REG_DDRB, 8'($urandom));
            write_reg(cia_reg_pkg::REG_PRA, 8'($urandom));
            write_reg(cia_reg_pkg::REG_PRB, 8'($urandom));
            read_reg(cia_reg_pkg::REG_PRA);
            read_reg(cia_reg_pkg::REG_PRB);
            read_reg(cia_reg_pkg::REG_DDRA);
        end

        // Timer A continuous, started by force load.
        lat_a = 8'($urandom_range(29, 6));
        write_reg(cia_reg_pkg::REG_TA_HI, 8'h00);
        write_reg(cia_reg_pkg::REG_TA_LO, lat_a);
        write_reg(cia_reg_pkg::REG_CRA, 8'h11);
        repeat (6) begin
            idle_cycles(int'($urandom_range(20, 1)));
            read_reg(cia_reg_pkg::REG_TA_LO);
            read_reg(cia_reg_pkg::REG_TA_HI);
        end
        write_reg(cia_reg_pkg::REG_CRA, 8'h00);

        // Timer A one-shot with its interrupt enabled.
        write_reg(cia_reg_pkg::REG_ICR, 8'h81);
        read_reg(cia_reg_pkg::REG_ICR);
        write_reg(cia_reg_pkg::REG_TA_LO, lat_a);
        write_reg(cia_reg_pkg::REG_TA_HI, 8'h00);
        write_reg(cia_reg_pkg::REG_CRA, 8'h19);
        wait_irq();
        idle_cycles(3);
        read_reg(cia_reg_pkg::REG_CRA);
        read_reg(cia_reg_pkg::REG_ICR);
        read_reg(cia_reg_pkg::REG_ICR);
        read_reg(cia_reg_pkg::REG_TA_LO);

        // Timer B counting timer A underflows.
        lat_a = 8'($urandom_range(9, 2));
        lat_b = 8'($urandom_range(4, 1));
        write_reg(cia_reg_pkg::REG_ICR, 8'h01);
        write_reg(cia_reg_pkg::REG_ICR, 8'h82);
        write_reg(cia_reg_pkg::REG_TB_LO, lat_b);
        write_reg(cia_reg_pkg::REG_TB_HI, 8'h00);
        write_reg(cia_reg_pkg::REG_TA_LO, lat_a);
        write_reg(cia_reg_pkg::REG_TA_HI, 8'h00);
        write_reg(cia_reg_pkg::REG_CRB, 8'h41);
        write_reg(cia_reg_pkg::REG_CRA, 8'h01);
        wait_irq();
        write_reg(cia_reg_pkg::REG_CRA, 8'h00);
        write_reg(cia_reg_pkg::REG_CRB, 8'h00);
        read_reg(cia_reg_pkg::REG_ICR);
        read_reg(cia_reg_pkg::REG_TB_LO);
        read_reg(cia_reg_pkg::REG_ICR);

        // FLAG edge, masked flag and the PC strobe.
        write_reg(cia_reg_pkg::REG_ICR, 8'h02);
        write_reg(cia_reg_pkg::REG_ICR, 8'h90);
        read_reg(cia_reg_pkg::REG_ICR);
        flag_n = 1'b0;
        idle_cycles(2);
        wait_irq();
        write_reg(cia_reg_pkg::REG_ICR, 8'h10);
        idle_cycles(2);
        read_reg(cia_reg_pkg::REG_ICR);
        flag_n = 1'b1;
        read_reg(cia_reg_pkg::REG_PRB);
        write_reg(cia_reg_pkg::REG_PRB, 8'($urandom));
        idle_cycles(3);

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== verilog/cia_bus_decode.sv ====
/*
 * Register bus decode.
 * Per-register write strobes, ICR read strobe, port B access flag
 * and the read data multiplexer.
 */

`timescale 1ns/1ps
`include "cia_cfg.svh"

module cia_bus_decode (
    input  logic                    CNT,
    input  logic                    RESET_n,
    input  logic                    cs,
    input  logic                    we,
    input  logic [`CIA_ADDR_W-1:0]  addr,
    input  cia_reg_pkg::byte_t      wdata,
    input  cia_reg_pkg::byte_t      pa_in,
    input  cia_reg_pkg::byte_t      pb_in,
    input  cia_reg_pkg::byte_t      ddra,
    input  cia_reg_pkg::byte_t      ddrb,
    input  cia_timer_pkg::count_t   ta_count,
    input  cia_timer_pkg::count_t   tb_count,
    input  cia_reg_pkg::byte_t      cra,
    input  cia_reg_pkg::byte_t      crb,
    input  cia_reg_pkg::byte_t      icr_read,
    output cia_reg_pkg::byte_t      rdata,
    output logic                    wr_pra,
    output logic                    wr_prb,
    output logic                    wr_ddra,
    output logic                    wr_ddrb,
    output logic                    wr_ta_lo,
    output logic                    wr_ta_hi,
    output logic                    wr_tb_lo,
    output logic                    wr_tb_hi,
    output logic                    wr_cra,
    output logic                    wr_crb,
    output logic                    wr_icr,
    output logic                    icr_rd,
    output logic                    prb_access
);

    cia_reg_pkg::reg_addr_e addr_e;
    logic                   wr;
    logic                   rd;

    assign addr_e = cia_reg_pkg::reg_addr_e'(addr);
    assign wr     = cs & we;
    assign rd     = cs & ~we;

    assign wr_pra   = wr && addr_e == cia_reg_pkg::REG_PRA;
    assign wr_prb   = wr && addr_e == cia_reg_pkg::REG_PRB;
    assign wr_ddra  = wr && addr_e == cia_reg_pkg::REG_DDRA;
    assign wr_ddrb  = wr && addr_e == cia_reg_pkg::REG_DDRB;
    assign wr_ta_lo = wr && addr_e == cia_reg_pkg::REG_TA_LO;
    assign wr_ta_hi = wr && addr_e == cia_reg_pkg::REG_TA_HI;
    assign wr_tb_lo = wr && addr_e == cia_reg_pkg::REG_TB_LO;
    assign wr_tb_hi = wr && addr_e == cia_reg_pkg::REG_TB_HI;
    assign wr_cra   = wr && addr_e == cia_reg_pkg::REG_CRA;
    assign wr_crb   = wr && addr_e == cia_reg_pkg::REG_CRB;

    // An ICR write naming no source bits leaves the mask as it is.
    assign wr_icr = wr && addr_e == cia_reg_pkg::REG_ICR && |wdata[`CIA_IRQ_SRCS-1:0];
    assign icr_rd = rd && addr_e == cia_reg_pkg::REG_ICR;

    // Port B read or write seen at the last edge, drives the PC pulse.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            prb_access <= 1'b0;
        end else begin
            prb_access <= cs && addr_e == cia_reg_pkg::REG_PRB;
        end
    end

    always_comb begin
        case (addr_e)
            cia_reg_pkg::REG_PRA:   rdata = pa_in;
            cia_reg_pkg::REG_PRB:   rdata = pb_in;
            cia_reg_pkg::REG_DDRA:  rdata = ddra;
            cia_reg_pkg::REG_DDRB:  rdata = ddrb;
            cia_reg_pkg::REG_TA_LO: rdata = ta_count[`CIA_DATA_W-1:0];
            cia_reg_pkg::REG_TA_HI: rdata = ta_count[`CIA_TIMER_W-1:`CIA_DATA_W];
            cia_reg_pkg::REG_TB_LO: rdata = tb_count[`CIA_DATA_W-1:0];
            cia_reg_pkg::REG_TB_HI: rdata = tb_count[`CIA_TIMER_W-1:`CIA_DATA_W];
            cia_reg_pkg::REG_ICR:   rdata = icr_read;
            cia_reg_pkg::REG_CRA:   rdata = cra;
            cia_reg_pkg::REG_CRB:   rdata = crb;
            default:                rdata = '0;
        endcase
    end

endmodule

// ==== verilog/cia_cfg.svh ====
/*
 * Width and count macros for the peripheral interface adapter.
 * Bus byte, register address, timer and interrupt source sizes.
 */

`ifndef CIA_CFG_SVH
`define CIA_CFG_SVH

// Bus and port byte.
`define CIA_DATA_W 8

// Register address, sixteen locations.
`define CIA_ADDR_W 4

// Interval timer counter and latch.
`define CIA_TIMER_W 16

// Interrupt sources held in the ICR.
`define CIA_IRQ_SRCS 5

`endif

// ==== verilog/cia_interrupt_ctrl.sv ====
/*
 * Interrupt control register.
 * Source mask, sticky flags with clear on read, and the IRQ output.
 */

`timescale 1ns/1ps
`include "cia_cfg.svh"

module cia_interrupt_ctrl (
    input  logic                CNT,
    input  logic                RESET_n,
    input  cia_reg_pkg::byte_t  wdata,
    input  logic                wr_icr,
    input  logic                icr_rd,
    input  logic                ta_underflow,
    input  logic                tb_underflow,
    input  logic                flag_fall,
    output cia_reg_pkg::byte_t  icr_read,
    output logic                irq_n
);

    cia_reg_pkg::irq_bits_t mask_q;
    cia_reg_pkg::irq_bits_t flags_q;
    cia_reg_pkg::irq_bits_t src;
    logic                   irq;

    // Bits 2 and 3 have no source left.
    always_comb begin
        src                         = '0;
        src[cia_reg_pkg::IRQ_TA]    = ta_underflow;
        src[cia_reg_pkg::IRQ_TB]    = tb_underflow;
        src[cia_reg_pkg::IRQ_FLAG]  = flag_fall;
    end

    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            mask_q  <= '0;
            flags_q <= '0;
        end else begin
            // Bit 7 selects set or clear of the named mask bits.
            if (wr_icr && wdata[`CIA_DATA_W-1])
                mask_q <= mask_q | wdata[`CIA_IRQ_SRCS-1:0];
            else if (wr_icr)
                mask_q <= mask_q & ~wdata[`CIA_IRQ_SRCS-1:0];
            // A read keeps only what fires in the read cycle.
            flags_q <= icr_rd ? src : (flags_q | src);
        end
    end

    assign irq      = |(flags_q & mask_q);
    assign irq_n    = ~irq;
    assign icr_read = {irq, {(`CIA_DATA_W - `CIA_IRQ_SRCS - 1){1'b0}}, flags_q};

endmodule

// ==== verilog/cia_io_ports.sv ====
/*
 * Parallel ports A and B.
 * Data and direction registers, PC strobe and FLAG falling edge detect.
 */

`timescale 1ns/1ps

module cia_io_ports (
    input  logic                CNT,
    input  logic                RESET_n,
    input  cia_reg_pkg::byte_t  wdata,
    input  logic                wr_pra,
    input  logic                wr_prb,
    input  logic                wr_ddra,
    input  logic                wr_ddrb,
    input  logic                prb_access,
    input  logic                flag_n,
    output cia_reg_pkg::byte_t  pa_out,
    output cia_reg_pkg::byte_t  pa_oe,
    output cia_reg_pkg::byte_t  pb_out,
    output cia_reg_pkg::byte_t  pb_oe,
    output cia_reg_pkg::byte_t  ddra,
    output cia_reg_pkg::byte_t  ddrb,
    output logic                pc_n,
    output logic                flag_fall
);

    cia_reg_pkg::byte_t pra_q;
    cia_reg_pkg::byte_t prb_q;
    logic               flag_n_q;

    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            pra_q <= '0;
            prb_q <= '0;
            ddra  <= '0;
            ddrb  <= '0;
        end else begin
            if (wr_pra)
                pra_q <= wdata;
            if (wr_prb)
                prb_q <= wdata;
            if (wr_ddra)
                ddra <= wdata;
            if (wr_ddrb)
                ddrb <= wdata;
        end
    end

    // Each direction bit enables its own pin driver.
    assign pa_out = pra_q;
    assign pa_oe  = ddra;
    assign pb_out = prb_q;
    assign pb_oe  = ddrb;

    // Low for the single cycle after a port B access.
    assign pc_n = ~prb_access;

    // Starts high so a low FLAG at reset release is not an edge.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n)
            flag_n_q <= 1'b1;
        else
            flag_n_q <= flag_n;
    end

    assign flag_fall = flag_n_q & ~flag_n;

endmodule

// ==== verilog/cia_reg_pkg.sv ====
/*
 * Register map of the adapter.
 * Address enumeration, bus byte type and interrupt flag bits.
 */

`include "cia_cfg.svh"

package cia_reg_pkg;

    typedef logic [`CIA_DATA_W-1:0] byte_t;

    typedef logic [`CIA_IRQ_SRCS-1:0] irq_bits_t;

    // Positions of the live sources inside irq_bits_t.
    localparam int IRQ_TA   = 0;
    localparam int IRQ_TB   = 1;
    localparam int IRQ_FLAG = 4;

    // Locations 8 to 12 held the clock and serial registers.
    typedef enum logic [`CIA_ADDR_W-1:0] {
        REG_PRA   = 4'h0,
        REG_PRB   = 4'h1,
        REG_DDRA  = 4'h2,
        REG_DDRB  = 4'h3,
        REG_TA_LO = 4'h4,
        REG_TA_HI = 4'h5,
        REG_TB_LO = 4'h6,
        REG_TB_HI = 4'h7,
        REG_RSV_8 = 4'h8,
        REG_RSV_9 = 4'h9,
        REG_RSV_A = 4'ha,
        REG_RSV_B = 4'hb,
        REG_RSV_C = 4'hc,
        REG_ICR   = 4'hd,
        REG_CRA   = 4'he,
        REG_CRB   = 4'hf
    } reg_addr_e;

endpackage

// ==== verilog/cia_timer_pkg.sv ====
/*
 * Interval timer types.
 * Counter type and the control byte with its timer A and timer B views.
 */

`include "cia_cfg.svh"

package cia_timer_pkg;

    typedef logic [`CIA_TIMER_W-1:0] count_t;

    // Control register A layout.
    typedef struct packed {
        logic [2:0] rsvd_hi;
        logic       load;
        logic       oneshot;
        logic [1:0] rsvd_lo;
        logic       start;
    } cra_view_t;

    // Control register B adds the cascade select.
    typedef struct packed {
        logic       rsvd_7;
        logic       cnt_ta;
        logic       rsvd_5;
        logic       load;
        logic       oneshot;
        logic [1:0] rsvd_lo;
        logic       start;
    } crb_view_t;

    // One written byte, read as either control register.
    typedef union packed {
        cra_view_t ta;
        crb_view_t tb;
    } ctrl_u;

endpackage

// ==== verilog/cia_timers.sv ====
/*
 * Interval timers A and B.
 * Latches, counters, control bits and the timer B cascade on A underflow.
 */

`timescale 1ns/1ps
`include "cia_cfg.svh"

module cia_timers (
    input  logic                    CNT,
    input  logic                    RESET_n,
    input  cia_reg_pkg::byte_t      wdata,
    input  logic                    wr_ta_lo,
    input  logic                    wr_ta_hi,
    input  logic                    wr_tb_lo,
    input  logic                    wr_tb_hi,
    input  logic                    wr_cra,
    input  logic                    wr_crb,
    output cia_timer_pkg::count_t   ta_count,
    output cia_timer_pkg::count_t   tb_count,
    output cia_reg_pkg::byte_t      cra,
    output cia_reg_pkg::byte_t      crb,
    output logic                    ta_underflow,
    output logic                    tb_underflow
);

    cia_timer_pkg::ctrl_u cr_w;
    cia_timer_pkg::ctrl_u cra_v;
    cia_timer_pkg::ctrl_u crb_v;
    logic [1:0] wr_lo, wr_hi, wr_cr;
    logic [1:0] cr_start, cr_oneshot, cr_load;
    logic [1:0] running, oneshot, zero, step, underflow;
    logic       tb_cascade;
    logic       tb_step;

    // Index 0 is timer A, index 1 is timer B.
    assign cr_w       = wdata;
    assign wr_lo      = {wr_tb_lo, wr_ta_lo};
    assign wr_hi      = {wr_tb_hi, wr_ta_hi};
    assign wr_cr      = {wr_crb, wr_cra};
    assign cr_start   = {cr_w.tb.start, cr_w.ta.start};
    assign cr_oneshot = {cr_w.tb.oneshot, cr_w.ta.oneshot};
    assign cr_load    = {cr_w.tb.load, cr_w.ta.load};

    // Timer B steps on every cycle, or only on A underflows in cascade mode.
    assign ta_underflow = running[0] & zero[0];
    assign tb_step      = running[1] & (~tb_cascade | ta_underflow);
    assign tb_underflow = tb_step & zero[1];
    assign step         = {tb_step, running[0]};
    assign underflow    = {tb_underflow, ta_underflow};

    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n)
            tb_cascade <= 1'b0;
        else if (wr_crb)
            tb_cascade <= cr_w.tb.cnt_ta;
    end

    for (genvar t = 0; t < 2; t++) begin : g_timer
        cia_timer_pkg::count_t count_q;
        cia_timer_pkg::count_t latch_q;
        logic                  running_q;
        logic                  oneshot_q;

        assign running[t] = running_q;
        assign oneshot[t] = oneshot_q;
        assign zero[t]    = count_q == '0;

        always_ff @(posedge CNT or negedge RESET_n) begin
            if (!RESET_n) begin
                latch_q <= '0;
            end else begin
                if (wr_lo[t])
                    latch_q[`CIA_DATA_W-1:0] <= wdata;
                if (wr_hi[t])
                    latch_q[`CIA_TIMER_W-1:`CIA_DATA_W] <= wdata;
            end
        end

        // Force load wins over a HI write, which wins over counting.
        always_ff @(posedge CNT or negedge RESET_n) begin
            if (!RESET_n)
                count_q <= '0;
            else if (wr_cr[t] && cr_load[t])
                count_q <= latch_q;
            else if (wr_hi[t] && !running_q)
                count_q <= {wdata, latch_q[`CIA_DATA_W-1:0]};
            else if (step[t])
                count_q <= underflow[t] ? latch_q : count_q - cia_timer_pkg::count_t'(1);
        end

        always_ff @(posedge CNT or negedge RESET_n) begin
            if (!RESET_n) begin
                running_q <= 1'b0;
                oneshot_q <= 1'b0;
            end else if (wr_cr[t]) begin
                running_q <= cr_start[t];
                oneshot_q <= cr_oneshot[t];
            end else if (underflow[t] && oneshot_q) begin
                running_q <= 1'b0;
            end
        end

        if (t == 0) begin : g_out_a
            assign ta_count = count_q;
        end else begin : g_out_b
            assign tb_count = count_q;
        end
    end

    // Load bits are strobes and read back as zero.
    always_comb begin
        cra_v            = '0;
        cra_v.ta.start   = running[0];
        cra_v.ta.oneshot = oneshot[0];
        crb_v            = '0;
        crb_v.tb.start   = running[1];
        crb_v.tb.oneshot = oneshot[1];
        crb_v.tb.cnt_ta  = tb_cascade;
    end

    assign cra = cra_v;
    assign crb = crb_v;

endmodule

// ==== verilog/cia_top.sv ====
/*
 * Adapter top level.
 * Connects bus decode, I/O ports, interval timers and interrupt control.
 */

`timescale 1ns/1ps
`include "cia_cfg.svh"

module cia_top (
    input  logic                    CNT,
    input  logic                    RESET_n,
    input  logic                    cs,
    input  logic                    we,
    input  logic [`CIA_ADDR_W-1:0]  addr,
    input  cia_reg_pkg::byte_t      wdata,
    output cia_reg_pkg::byte_t      rdata,
    input  cia_reg_pkg::byte_t      pa_in,
    output cia_reg_pkg::byte_t      pa_out,
    output cia_reg_pkg::byte_t      pa_oe,
    input  cia_reg_pkg::byte_t      pb_in,
    output cia_reg_pkg::byte_t      pb_out,
    output cia_reg_pkg::byte_t      pb_oe,
    input  logic                    flag_n,
    output logic                    pc_n,
    output logic                    irq_n
);

    logic wr_pra, wr_prb, wr_ddra, wr_ddrb;
    logic wr_ta_lo, wr_ta_hi, wr_tb_lo, wr_tb_hi;
    logic wr_cra, wr_crb, wr_icr;
    logic icr_rd, prb_access;
    logic ta_underflow, tb_underflow, flag_fall;

    cia_reg_pkg::byte_t    ddra, ddrb, cra, crb, icr_read;
    cia_timer_pkg::count_t ta_count, tb_count;

    cia_bus_decode i_bus_decode (
        .CNT(CNT), .RESET_n(RESET_n), .cs(cs), .we(we), .addr(addr), .wdata(wdata),
        .pa_in(pa_in), .pb_in(pb_in), .ddra(ddra), .ddrb(ddrb),
        .ta_count(ta_count), .tb_count(tb_count), .cra(cra), .crb(crb),
        .icr_read(icr_read), .rdata(rdata),
        .wr_pra(wr_pra), .wr_prb(wr_prb), .wr_ddra(wr_ddra), .wr_ddrb(wr_ddrb),
        .wr_ta_lo(wr_ta_lo), .wr_ta_hi(wr_ta_hi), .wr_tb_lo(wr_tb_lo), .wr_tb_hi(wr_tb_hi),
        .wr_cra(wr_cra), .wr_crb(wr_crb), .wr_icr(wr_icr),
        .icr_rd(icr_rd), .prb_access(prb_access)
    );

    cia_io_ports i_io_ports (
        .CNT(CNT), .RESET_n(RESET_n), .wdata(wdata),
        .wr_pra(wr_pra), .wr_prb(wr_prb), .wr_ddra(wr_ddra), .wr_ddrb(wr_ddrb),
        .prb_access(prb_access), .flag_n(flag_n),
        .pa_out(pa_out), .pa_oe(pa_oe), .pb_out(pb_out), .pb_oe(pb_oe),
        .ddra(ddra), .ddrb(ddrb), .pc_n(pc_n), .flag_fall(flag_fall)
    );

    cia_timers i_timers (
        .CNT(CNT), .RESET_n(RESET_n), .wdata(wdata),
        .wr_ta_lo(wr_ta_lo), .wr_ta_hi(wr_ta_hi), .wr_tb_lo(wr_tb_lo), .wr_tb_hi(wr_tb_hi),
        .wr_cra(wr_cra), .wr_crb(wr_crb),
        .ta_count(ta_count), .tb_count(tb_count), .cra(cra), .crb(crb),
        .ta_underflow(ta_underflow), .tb_underflow(tb_underflow)
    );

    cia_interrupt_ctrl i_interrupt_ctrl (
        .CNT(CNT), .RESET_n(RESET_n), .wdata(wdata),
        .wr_icr(wr_icr), .icr_rd(icr_rd),
        .ta_underflow(ta_underflow), .tb_underflow(tb_underflow), .flag_fall(flag_fall),
        .icr_read(icr_read), .irq_n(irq_n)
    );

endmodule
